//--- common/mr_status_pkg.sv
/*
 * Bit positions and field widths of the 64-bit OSD status word.
 * Also holds the crop scale modes that the HDMI crop logic checks.
 */

`default_nettype none

package mr_status_pkg;

    localparam int status_w = 64;

    // Scanline effect, 3 bits
    localparam int st_fx_lo = 3;
    localparam int st_fx_hi = 5;

    // User port selection
    localparam int st_db15_bit = 37;
    localparam int st_uart_bit = 38;

    // Vertical crop controls
    localparam int st_crop_en_bit = 41;
    localparam int st_vcopt_lo    = 42;
    localparam int st_scale_lo    = 46;

    // CRT horizontal scaling
    localparam int st_hsize_bit = 48;

    localparam int vcopt_w     = 4;
    localparam int crop_off_w  = 5;
    localparam int crop_size_w = 12;

    // Scaler modes, only normal tolerates cropping
    typedef enum logic [2:0] {
        scale_normal           = 3'd0,
        scale_v_integer        = 3'd1,
        scale_hv_integer_minus = 3'd2,
        scale_hv_integer_plus  = 3'd3,
        scale_hv_integer       = 3'd4
    } crop_scale_e;

endpackage

`default_nettype wire

//--- common/mr_periph_pkg.sv
/*
 * Peripheral definitions: user port modes, PS/2 mouse packet layout,
 * debug bus groups and the OSD menu mask width.
 */

`default_nettype none

package mr_periph_pkg;

    // Shared user port, DB15 joystick or UART
    localparam int user_w = 7;

    typedef enum logic [1:0] {
        port_idle = 2'd0,
        port_db15 = 2'd1,
        port_uart = 2'd2
    } port_mode_e;

    // PS/2 mouse packet, top bit toggles on each new packet
    localparam int mouse_pkt_w  = 25;
    localparam int mouse_axis_w = 9;

    // Group picked by the top two bits of the debug bus
    typedef enum logic [1:0] {
        dbg_mouse  = 2'd0,
        dbg_status = 2'd1,
        dbg_port   = 2'd2,
        dbg_echo   = 2'd3
    } dbg_group_e;

    // High bit hides the matching OSD menu item
    localparam int menumask_w = 16;

endpackage

`default_nettype wire

//--- hdl/mr_status_decode.sv
/*
 * Splits the OSD status word into named control fields, one register
 * stage. The user port mode gives DB15 priority over UART.
 */

`timescale 1ns/1ps
`default_nettype none

module mr_status_decode (
    input  logic                                clk_sys,
    input  logic                                arst_n,
    input  logic [mr_status_pkg::status_w-1:0]  status,
    output mr_periph_pkg::port_mode_e           port_mode,
    output logic                                uart_en,
    output logic                                crop_en,
    output logic                                hsize_en,
    output logic [mr_status_pkg::vcopt_w-1:0]   vcopt,
    output mr_status_pkg::crop_scale_e          crop_scale,
    output logic [mr_status_pkg::st_fx_hi-mr_status_pkg::st_fx_lo:0] fx
);

    mr_periph_pkg::port_mode_e mode_next;

    // DB15 wins when both port bits are set
    always_comb begin
        if (status[mr_status_pkg::st_db15_bit]) begin
            mode_next = mr_periph_pkg::port_db15;
        end else if (status[mr_status_pkg::st_uart_bit]) begin
            mode_next = mr_periph_pkg::port_uart;
        end else begin
            mode_next = mr_periph_pkg::port_idle;
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            port_mode  <= mr_periph_pkg::port_idle;
            uart_en    <= 1'b0;
            crop_en    <= 1'b0;
            hsize_en   <= 1'b0;
            vcopt      <= '0;
            crop_scale <= mr_status_pkg::scale_normal;
            fx         <= '0;
        end else begin
            port_mode <= mode_next;
            uart_en   <= status[mr_status_pkg::st_uart_bit];
            crop_en   <= status[mr_status_pkg::st_crop_en_bit];
            hsize_en  <= status[mr_status_pkg::st_hsize_bit];
            vcopt     <= status[mr_status_pkg::st_vcopt_lo +: mr_status_pkg::vcopt_w];
            // Only two scale bits live in the status word
            crop_scale <= mr_status_pkg::crop_scale_e'(
                {1'b0, status[mr_status_pkg::st_scale_lo +: 2]});
            fx <= status[mr_status_pkg::st_fx_hi:mr_status_pkg::st_fx_lo];
        end
    end

endmodule

`default_nettype wire

//--- periph/mr_user_port.sv
/*
 * Drives the shared user port pins from the DB15 joystick logic, the game
 * UART or the idle level, and gates the UART receive line.
 */

`timescale 1ns/1ps
`default_nettype none

module mr_user_port (
    input  logic                              clk_sys,
    input  logic                              arst_n,
    input  mr_periph_pkg::port_mode_e         port_mode,
    input  logic                              uart_en,
    input  logic [mr_periph_pkg::user_w-1:0]  user_in,
    input  logic [mr_periph_pkg::user_w-1:0]  db15_out,
    input  logic                              game_tx,
    output logic [mr_periph_pkg::user_w-1:0]  user_out,
    output logic                              uart_rx
);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            user_out <= '1;
        end else begin
            case (port_mode)
                mr_periph_pkg::port_db15: begin
                    user_out <= db15_out;
                end
                mr_periph_pkg::port_uart: begin
                    // TX on pin 0, the rest held high
                    user_out <= {{(mr_periph_pkg::user_w-1){1'b1}}, game_tx};
                end
                default: begin
                    user_out <= '1;
                end
            endcase
        end
    end

    // RX idles high while the UART is off
    assign uart_rx = uart_en ? user_in[1] : 1'b1;

endmodule

`default_nettype wire

//--- periph/mr_mouse_decode.sv
/*
 * Unpacks PS/2 mouse packets into signed motion and button flags.
 * A one-cycle strobe marks each new packet, seen as a toggle of the top bit.
 */

`timescale 1ns/1ps
`default_nettype none

module mr_mouse_decode (
    input  logic                                   clk_sys,
    input  logic                                   arst_n,
    input  logic [mr_periph_pkg::mouse_pkt_w-1:0]  ps2_mouse,
    output logic [mr_periph_pkg::mouse_axis_w-1:0] mouse_dx,
    output logic [mr_periph_pkg::mouse_axis_w-1:0] mouse_dy,
    output logic [7:0]                             mouse_f,
    output logic                                   mouse_strobe
);

    logic toggle_q;
    logic toggle_in;

    assign toggle_in = ps2_mouse[mr_periph_pkg::mouse_pkt_w-1];

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            toggle_q     <= 1'b0;
            mouse_strobe <= 1'b0;
            mouse_dx     <= '0;
            mouse_dy     <= '0;
            mouse_f      <= '0;
        end else begin
            toggle_q     <= toggle_in;
            mouse_strobe <= toggle_in ^ toggle_q;
            mouse_f      <= ps2_mouse[7:0];
            // Sign bits come from the flag byte, bits 4 and 5
            mouse_dx <= {ps2_mouse[4], ps2_mouse[15:8]};
            mouse_dy <= {ps2_mouse[5], ps2_mouse[23:16]};
        end
    end

endmodule

`default_nettype wire

//--- video/mr_crop_ctrl.sv
/*
 * Vertical crop control for a 1080p HDMI output. Checks that the video
 * settings allow cropping, then gives the crop offset and crop height.
 */

`timescale 1ns/1ps
`default_nettype none

module mr_crop_ctrl #(
    parameter int hdmi_target_w = 1920,
    parameter int hdmi_target_h = 1080,
    parameter int crop_lines    = 216
) (
    input  logic                                  clk_sys,
    input  logic                                  arst_n,
    input  logic [11:0]                           hdmi_width,
    input  logic [11:0]                           hdmi_height,
    input  logic                                  force_scan2x,
    input  logic                                  direct_video,
    input  logic                                  rotate_en,
    input  logic                                  crop_en,
    input  logic [mr_status_pkg::vcopt_w-1:0]     vcopt,
    input  mr_status_pkg::crop_scale_e            crop_scale,
    input  logic [mr_status_pkg::st_fx_hi-mr_status_pkg::st_fx_lo:0] fx,
    output logic                                  crop_ok,
    output logic [mr_status_pkg::crop_off_w-1:0]  crop_off,
    output logic [mr_status_pkg::crop_size_w-1:0] crop_size
);

    logic                                 size_match;
    logic                                 ok_next;
    logic [mr_status_pkg::crop_off_w-1:0] off_x2;

    assign size_match = (hdmi_width == 12'(hdmi_target_w)) &&
                        (hdmi_height == 12'(hdmi_target_h));

    // No scanline FX, scan doubler, scaling, direct video or rotation
    assign ok_next = size_match && (fx == '0) && !force_scan2x &&
                     (crop_scale == mr_status_pkg::scale_normal) &&
                     !direct_video && !rotate_en;

    // Options 6 and up wrap to negative offsets
    assign off_x2 = {vcopt, 1'b0};

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            crop_ok   <= 1'b0;
            crop_off  <= '0;
            crop_size <= '0;
        end else begin
            crop_ok <= ok_next;
            if (vcopt < 4'd6) begin
                crop_off <= off_x2;
            end else begin
                crop_off <= off_x2 - 5'd24;
            end
            // Uses the registered crop_ok, one cycle behind it
            crop_size <= (crop_ok && crop_en) ?
                         mr_status_pkg::crop_size_w'(crop_lines) : '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mr_osd_report.sv
/*
 * OSD report: the menu visibility mask sent back with the status word and
 * a debug byte chosen by the debug bus. Both outputs are registered.
 */

`timescale 1ns/1ps
`default_nettype none

module mr_osd_report #(
    parameter int rotate_menu = 0
) (
    input  logic                                   clk_sys,
    input  logic                                   arst_n,
    input  logic [mr_status_pkg::status_w-1:0]     status,
    input  logic [7:0]                             debug_bus,
    input  logic                                   core_vertical,
    input  logic                                   direct_video,
    input  logic                                   hsize_en,
    input  logic                                   crop_ok,
    input  logic [mr_periph_pkg::mouse_axis_w-1:0] mouse_dx,
    input  logic [mr_periph_pkg::mouse_axis_w-1:0] mouse_dy,
    input  logic [7:0]                             mouse_f,
    output logic [mr_periph_pkg::menumask_w-1:0]   menumask,
    output logic [7:0]                             target_info
);

    localparam int axis_msb = mr_periph_pkg::mouse_axis_w - 1;

    logic [mr_periph_pkg::menumask_w-1:0] mask_next;
    logic [7:0]                           info_next;
    mr_periph_pkg::dbg_group_e            dbg_group;

    assign dbg_group = mr_periph_pkg::dbg_group_e'(debug_bus[7:6]);

    // A set bit hides the item; vertical games show one of two rotate menus
    always_comb begin
        mask_next    = '0;
        mask_next[0] = direct_video;
        mask_next[1] = (rotate_menu == 0) ? ~core_vertical : 1'b1;
        mask_next[2] = ~hsize_en;
        mask_next[3] = 1'b1;
        mask_next[4] = (rotate_menu == 1) ? ~core_vertical : 1'b1;
        mask_next[5] = crop_ok;
    end

    always_comb begin
        case (dbg_group)
            mr_periph_pkg::dbg_mouse: begin
                case (debug_bus[1:0])
                    2'd0:    info_next = mouse_dx[7:0];
                    2'd1:    info_next = mouse_dy[7:0];
                    2'd2:    info_next = mouse_f;
                    default: info_next = {6'd0, mouse_dy[axis_msb], mouse_dx[axis_msb]};
                endcase
            end
            mr_periph_pkg::dbg_status: begin
                info_next = status[{debug_bus[2:0], 3'b000} +: 8];
            end
            mr_periph_pkg::dbg_port: begin
                info_next = mask_next[7:0];
            end
            default: begin
                info_next = debug_bus;
            end
        endcase
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            menumask    <= mr_periph_pkg::menumask_w'(16'h0008);
            target_info <= '0;
        end else begin
            menumask    <= mask_next;
            target_info <= info_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mr_frame_top.sv
/*
 * Frame control glue for an arcade core wrapper. Decodes the OSD status,
 * drives the user port, decodes the mouse, controls 1080p crop and builds
 * the OSD report. Everything runs on clk_sys.
 */

`timescale 1ns/1ps
`default_nettype none

module mr_frame_top #(
    parameter int hdmi_target_w = 1920,
    parameter int hdmi_target_h = 1080,
    parameter int crop_lines    = 216,
    parameter int rotate_menu   = 0
) (
    input  logic                                   clk_sys,
    input  logic                                   arst_n,
    input  logic [mr_status_pkg::status_w-1:0]     status,
    input  logic [mr_periph_pkg::user_w-1:0]       user_in,
    input  logic [mr_periph_pkg::user_w-1:0]       db15_out,
    input  logic                                   game_tx,
    input  logic [mr_periph_pkg::mouse_pkt_w-1:0]  ps2_mouse,
    input  logic [11:0]                            hdmi_width,
    input  logic [11:0]                            hdmi_height,
    input  logic                                   force_scan2x,
    input  logic                                   direct_video,
    input  logic                                   rotate_en,
    input  logic                                   core_vertical,
    input  logic [7:0]                             debug_bus,
    output logic [mr_periph_pkg::user_w-1:0]       user_out,
    output logic                                   game_rx,
    output logic [mr_periph_pkg::mouse_axis_w-1:0] mouse_dx,
    output logic [mr_periph_pkg::mouse_axis_w-1:0] mouse_dy,
    output logic [7:0]                             mouse_f,
    output logic                                   mouse_strobe,
    output logic [mr_status_pkg::crop_off_w-1:0]   crop_off,
    output logic [mr_status_pkg::crop_size_w-1:0]  crop_size,
    output logic [mr_periph_pkg::menumask_w-1:0]   menumask,
    output logic [7:0]                             target_info
);

    mr_periph_pkg::port_mode_e                port_mode;
    mr_status_pkg::crop_scale_e               crop_scale;
    logic                                     uart_en;
    logic                                     crop_en;
    logic                                     hsize_en;
    logic [mr_status_pkg::vcopt_w-1:0]        vcopt;
    logic [mr_status_pkg::st_fx_hi-mr_status_pkg::st_fx_lo:0] fx;
    logic                                     crop_ok;

    // Decode stage
    mr_status_decode mr_status_decode_inst (
        .clk_sys    (clk_sys),
        .arst_n     (arst_n),
        .status     (status),
        .port_mode  (port_mode),
        .uart_en    (uart_en),
        .crop_en    (crop_en),
        .hsize_en   (hsize_en),
        .vcopt      (vcopt),
        .crop_scale (crop_scale),
        .fx         (fx)
    );

    // Execute stage
    mr_user_port mr_user_port_inst (
        .clk_sys   (clk_sys),
        .arst_n    (arst_n),
        .port_mode (port_mode),
        .uart_en   (uart_en),
        .user_in   (user_in),
        .db15_out  (db15_out),
        .game_tx   (game_tx),
        .user_out  (user_out),
        .uart_rx   (game_rx)
    );

    mr_mouse_decode mr_mouse_decode_inst (
        .clk_sys      (clk_sys),
        .arst_n       (arst_n),
        .ps2_mouse    (ps2_mouse),
        .mouse_dx     (mouse_dx),
        .mouse_dy     (mouse_dy),
        .mouse_f      (mouse_f),
        .mouse_strobe (mouse_strobe)
    );

    mr_crop_ctrl #(
        .hdmi_target_w (hdmi_target_w),
        .hdmi_target_h (hdmi_target_h),
        .crop_lines    (crop_lines)
    ) mr_crop_ctrl_inst (
        .clk_sys      (clk_sys),
        .arst_n       (arst_n),
        .hdmi_width   (hdmi_width),
        .hdmi_height  (hdmi_height),
        .force_scan2x (force_scan2x),
        .direct_video (direct_video),
        .rotate_en    (rotate_en),
        .crop_en      (crop_en),
        .vcopt        (vcopt),
        .crop_scale   (crop_scale),
        .fx           (fx),
        .crop_ok      (crop_ok),
        .crop_off     (crop_off),
        .crop_size    (crop_size)
    );

    // Result stage
    mr_osd_report #(
        .rotate_menu (rotate_menu)
    ) mr_osd_report_inst (
        .clk_sys       (clk_sys),
        .arst_n        (arst_n),
        .status        (status),
        .debug_bus     (debug_bus),
        .core_vertical (core_vertical),
        .direct_video  (direct_video),
        .hsize_en      (hsize_en),
        .crop_ok       (crop_ok),
        .mouse_dx      (mouse_dx),
        .mouse_dy      (mouse_dy),
        .mouse_f       (mouse_f),
        .menumask      (menumask),
        .target_info   (target_info)
    );

endmodule

`default_nettype wire

//--- bench/mr_frame_checker.sv
/*
 * Concurrent assertions on the frame control top level, bound to
 * mr_frame_top from the testbench. Failures are also counted.
 */

`timescale 1ns/1ps
`default_nettype none

module mr_frame_checker #(
    parameter int crop_lines = 216
) (
    input logic                                  clk_sys,
    input logic                                  arst_n,
    input logic                                  mouse_strobe,
    input logic [mr_status_pkg::crop_size_w-1:0] crop_size,
    input logic [mr_periph_pkg::menumask_w-1:0]  menumask,
    input logic [mr_periph_pkg::user_w-1:0]      user_out
);

    int assert_fails = 0;

    // One strobe cycle per packet
    strobe_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
        mouse_strobe |=> !mouse_strobe)
        else begin
            $error("mouse_strobe stayed high for two cycles");
            assert_fails++;
        end

    crop_size_value: assert property (@(posedge clk_sys) disable iff (!arst_n)
        (crop_size != '0) |-> (crop_size == crop_lines))
        else begin
            $error("crop_size is nonzero but not the crop height");
            assert_fails++;
        end

    mask_bit3_set: assert property (@(posedge clk_sys) disable iff (!arst_n)
        menumask[3])
        else begin
            $error("menumask bit 3 is low");
            assert_fails++;
        end

    // Port pins idle high while reset is held
    idle_in_reset: assert property (@(posedge clk_sys)
        !arst_n |-> (user_out == '1))
        else begin
            $error("user_out not all ones during reset");
            assert_fails++;
        end

endmodule

`default_nettype wire

//--- bench/mr_frame_tb.sv
/*
 * Testbench for the frame control glue. Drives seeded random stimulus
 * through reset, user port, mouse, crop and OSD report phases and compares
 * every output against a cycle model each clock.
 */

`timescale 1ns/1ps
`default_nettype none

module mr_frame_tb;

    localparam int crop_lines   = 216;
    localparam int rotate_menu  = 1;
    localparam int port_iters   = 200;
    localparam int mouse_cycles = 400;
    localparam int crop_iters   = 150;
    localparam int osd_cycles   = 300;
    // Port steps take three cycles, crop steps four
    localparam int cycle_limit  = 2 * (10 + 3 * port_iters + mouse_cycles +
                                       4 * crop_iters + osd_cycles + 16);

    logic        clk_sys;
    logic        arst_n;
    logic [63:0] status;
    logic [6:0]  user_in;
    logic [6:0]  db15_out;
    logic        game_tx;
    logic [24:0] ps2_mouse;
    logic [11:0] hdmi_width;
    logic [11:0] hdmi_height;
    logic        force_scan2x;
    logic        direct_video;
    logic        rotate_en;
    logic        core_vertical;
    logic [7:0]  debug_bus;
    logic [6:0]  user_out;
    logic        game_rx;
    logic [8:0]  mouse_dx;
    logic [8:0]  mouse_dy;
    logic [7:0]  mouse_f;
    logic        mouse_strobe;
    logic [4:0]  crop_off;
    logic [11:0] crop_size;
    logic [15:0] menumask;
    logic [7:0]  target_info;

    int    seed = 83;
    int    errors = 0;
    int    checks_run = 0;
    int    strobe_count = 0;
    int    cycle_count = 0;
    string test_name;
    logic  check_on;

    // Reference model state
    logic [1:0]  m_mode;
    logic        m_uart_en;
    logic        m_crop_en;
    logic        m_hsize;
    logic        m_crop_ok;
    logic        m_tog;
    logic        m_strobe;
    logic [3:0]  m_vcopt;
    logic [1:0]  m_scale;
    logic [2:0]  m_fx;
    logic [6:0]  m_user_out;
    logic [8:0]  m_dx;
    logic [8:0]  m_dy;
    logic [7:0]  m_f;
    logic [7:0]  m_info;
    logic [4:0]  m_crop_off;
    logic [11:0] m_crop_size;
    logic [15:0] m_mask;

    mr_frame_top #(
        .hdmi_target_w (1920),
        .hdmi_target_h (1080),
        .crop_lines    (crop_lines),
        .rotate_menu   (rotate_menu)
    ) mr_frame_top_inst (
        .clk_sys       (clk_sys),
        .arst_n        (arst_n),
        .status        (status),
        .user_in       (user_in),
        .db15_out      (db15_out),
        .game_tx       (game_tx),
        .ps2_mouse     (ps2_mouse),
        .hdmi_width    (hdmi_width),
        .hdmi_height   (hdmi_height),
        .force_scan2x  (force_scan2x),
        .direct_video  (direct_video),
        .rotate_en     (rotate_en),
        .core_vertical (core_vertical),
        .debug_bus     (debug_bus),
        .user_out      (user_out),
        .game_rx       (game_rx),
        .mouse_dx      (mouse_dx),
        .mouse_dy      (mouse_dy),
        .mouse_f       (mouse_f),
        .mouse_strobe  (mouse_strobe),
        .crop_off      (crop_off),
        .crop_size     (crop_size),
        .menumask      (menumask),
        .target_info   (target_info)
    );

    bind mr_frame_top mr_frame_checker #(
        .crop_lines (crop_lines)
    ) mr_frame_checker_inst (
        .clk_sys      (clk_sys),
        .arst_n       (arst_n),
        .mouse_strobe (mouse_strobe),
        .crop_size    (crop_size),
        .menumask     (menumask),
        .user_out     (user_out)
    );

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    task automatic check_val(input string field, input logic [63:0] expected,
                             input logic [63:0] actual);
        checks_run++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
        end
    endtask

    // A set bit hides the menu item
    function automatic logic [15:0] expected_mask(input logic dv, input logic vert,
                                                  input logic hsize, input logic ok);
        logic [15:0] mask;
        mask    = 16'h0008;
        mask[0] = dv;
        mask[1] = (rotate_menu == 0) ? !vert : 1'b1;
        mask[2] = !hsize;
        mask[4] = (rotate_menu == 1) ? !vert : 1'b1;
        mask[5] = ok;
        return mask;
    endfunction

    function automatic logic [7:0] expected_info(input logic [7:0] dbg, input logic [63:0] st,
                                                 input logic [7:0] mask_low);
        case (dbg[7:6])
            2'd0: begin
                case (dbg[1:0])
                    2'd0:    return m_dx[7:0];
                    2'd1:    return m_dy[7:0];
                    2'd2:    return m_f;
                    default: return {6'd0, m_dy[8], m_dx[8]};
                endcase
            end
            2'd1:    return st[dbg[2:0] * 8 +: 8];
            2'd2:    return mask_low;
            default: return dbg;
        endcase
    endfunction

    always @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            m_mode      <= 2'd0;
            m_uart_en   <= 1'b0;
            m_crop_en   <= 1'b0;
            m_hsize     <= 1'b0;
            m_vcopt     <= '0;
            m_scale     <= '0;
            m_fx        <= '0;
            m_user_out  <= '1;
            m_tog       <= 1'b0;
            m_strobe    <= 1'b0;
            m_dx        <= '0;
            m_dy        <= '0;
            m_f         <= '0;
            m_crop_ok   <= 1'b0;
            m_crop_off  <= '0;
            m_crop_size <= '0;
            m_mask      <= 16'h0008;
            m_info      <= '0;
        end else begin
            // DB15 wins over UART
            m_mode    <= status[mr_status_pkg::st_db15_bit] ? 2'd1 :
                         (status[mr_status_pkg::st_uart_bit] ? 2'd2 : 2'd0);
            m_uart_en <= status[mr_status_pkg::st_uart_bit];
            m_crop_en <= status[mr_status_pkg::st_crop_en_bit];
            m_hsize   <= status[mr_status_pkg::st_hsize_bit];
            m_vcopt   <= status[mr_status_pkg::st_vcopt_lo +: 4];
            m_scale   <= status[mr_status_pkg::st_scale_lo +: 2];
            m_fx      <= status[mr_status_pkg::st_fx_lo +: 3];
            case (m_mode)
                2'd1:    m_user_out <= db15_out;
                2'd2:    m_user_out <= {6'h3f, game_tx};
                default: m_user_out <= 7'h7f;
            endcase
            m_tog    <= ps2_mouse[24];
            m_strobe <= ps2_mouse[24] ^ m_tog;
            m_f      <= ps2_mouse[7:0];
            m_dx     <= {ps2_mouse[4], ps2_mouse[15:8]};
            m_dy     <= {ps2_mouse[5], ps2_mouse[23:16]};
            m_crop_ok <= (hdmi_width == 12'd1920) && (hdmi_height == 12'd1080) &&
                         (m_fx == 3'd0) && !force_scan2x && (m_scale == 2'd0) &&
                         !direct_video && !rotate_en;
            m_crop_off  <= (m_vcopt < 4'd6) ? 5'(2 * m_vcopt) : 5'(2 * m_vcopt - 24);
            m_crop_size <= (m_crop_ok && m_crop_en) ? 12'(crop_lines) : 12'd0;
            m_mask <= expected_mask(direct_video, core_vertical, m_hsize, m_crop_ok);
            m_info <= expected_info(debug_bus, status,
                          expected_mask(direct_video, core_vertical, m_hsize, m_crop_ok));
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk_sys) begin
        if (mouse_strobe === 1'b1) begin
            strobe_count++;
        end
        if (check_on) begin
            check_val("user_out", m_user_out, user_out);
            check_val("game_rx", m_uart_en ? user_in[1] : 1'b1, game_rx);
            check_val("mouse_dx", m_dx, mouse_dx);
            check_val("mouse_dy", m_dy, mouse_dy);
            check_val("mouse_f", m_f, mouse_f);
            check_val("mouse_strobe", m_strobe, mouse_strobe);
            check_val("crop_off", m_crop_off, crop_off);
            check_val("crop_size", m_crop_size, crop_size);
            check_val("menumask", m_mask, menumask);
            check_val("target_info", m_info, target_info);
        end
    end

    initial begin
        int   i;
        int   flips;
        int   strobes_before;
        int   assert_errors;
        logic toggle;
        logic last_flip;
        status = '0;
        user_in = '0;
        db15_out = '0;
        game_tx = 1'b0;
        ps2_mouse = '0;
        hdmi_width = '0;
        hdmi_height = '0;
        force_scan2x = 1'b0;
        direct_video = 1'b0;
        rotate_en = 1'b0;
        core_vertical = 1'b0;
        debug_bus = '0;
        check_on = 1'b0;
        test_name = "reset";
        arst_n = 1'b1;
        #1;
        arst_n = 1'b0;
        repeat (9) @(posedge clk_sys);
        @(negedge clk_sys);
        check_val("user_out", 7'h7f, user_out);
        check_val("mouse_strobe", 1'b0, mouse_strobe);
        check_val("crop_size", 12'd0, crop_size);
        check_val("target_info", 8'd0, target_info);
        @(posedge clk_sys);
        #1;
        arst_n = 1'b1;
        check_on = 1'b1;

        test_name = "user_port";
        for (i = 0; i < port_iters; i++) begin
            status = {$random(seed), $random(seed)};
            wait_cycles(2);
            user_in = 7'($random(seed));
            db15_out = 7'($random(seed));
            game_tx = 1'($random(seed));
            wait_cycles(1);
        end

        test_name = "mouse";
        flips = 0;
        last_flip = 1'b0;
        strobes_before = strobe_count;
        for (i = 0; i < mouse_cycles; i++) begin
            toggle = ps2_mouse[24];
            // Packets never arrive on back to back cycles
            if (!last_flip && (($random(seed) & 3) == 0)) begin
                toggle = !toggle;
                flips++;
                last_flip = 1'b1;
            end else begin
                last_flip = 1'b0;
            end
            ps2_mouse = {toggle, 24'($random(seed))};
            wait_cycles(1);
        end
        wait_cycles(3);
        check_val("strobe count", flips, strobe_count - strobes_before);

        test_name = "crop";
        for (i = 0; i < crop_iters; i++) begin
            status = {$random(seed), $random(seed)};
            // Blockers kept rare so crop is often allowed
            if (($random(seed) & 3) != 0) begin
                status[mr_status_pkg::st_fx_lo +: 3] = '0;
            end
            if (($random(seed) & 3) != 0) begin
                status[mr_status_pkg::st_scale_lo +: 2] = '0;
            end
            if (($random(seed) & 1) != 0) begin
                hdmi_width = 12'd1920;
                hdmi_height = 12'd1080;
            end else begin
                hdmi_width = 12'($random(seed));
                hdmi_height = 12'($random(seed));
            end
            force_scan2x = (($random(seed) & 7) == 0);
            direct_video = (($random(seed) & 7) == 0);
            rotate_en = (($random(seed) & 7) == 0);
            wait_cycles(4);
        end

        test_name = "osd_report";
        for (i = 0; i < osd_cycles; i++) begin
            debug_bus = 8'($random(seed));
            core_vertical = 1'($random(seed));
            direct_video = 1'($random(seed));
            if ((i % 8) == 0) begin
                status = {$random(seed), $random(seed)};
            end
            wait_cycles(1);
        end
        wait_cycles(2);
        check_on = 1'b0;

        assert_errors = mr_frame_top_inst.mr_frame_checker_inst.assert_fails;
        $display("Checks %0d, value errors %0d, assertion errors %0d",
                 checks_run, errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
common/mr_status_pkg.sv
common/mr_periph_pkg.sv
hdl/mr_status_decode.sv
periph/mr_user_port.sv
periph/mr_mouse_decode.sv
video/mr_crop_ctrl.sv
hdl/mr_osd_report.sv
hdl/mr_frame_top.sv
bench/mr_frame_checker.sv
bench/mr_frame_tb.sv
